// File: include/fm_cfg.svh
// FM core configuration: slot timing, busy length, timer B prescale and register map
`ifndef FM_CFG_SVH
`define FM_CFG_SVH

// cen ticks per output sample
`define FM_SLOTS          32

// cen ticks of busy after each accepted data write
`define FM_BUSY_CEN       32

// samples per timer B step
`define FM_TB_PRESCALE    16

// register map
`define FM_REG_KEYON      8'h08
`define FM_REG_CLKA1      8'h10   // value_a[9:2]
`define FM_REG_CLKA2      8'h11   // value_a[1:0] in bits 1:0
`define FM_REG_CLKB       8'h12
`define FM_REG_TIMER_CTRL 8'h14
`define FM_REG_RL         8'h20
`define FM_REG_FREQ_HI    8'h28
`define FM_REG_FREQ_LO    8'h30
`define FM_REG_TL         8'h60
`define FM_REG_AR         8'h80

`endif

// File: src/fm_pkg.sv
// FM core package: shared widths, configuration structs and envelope states
`default_nettype none

package fm_pkg;

    typedef logic [7:0]         fm_byte_t;  // bus byte / register value
    typedef logic [9:0]         timer_a_t;
    typedef logic [7:0]         timer_b_t;
    typedef logic [4:0]         slot_t;
    typedef logic [15:0]        phase_t;
    typedef logic [6:0]         level_t;    // 0 silent, 127 full
    typedef logic signed [15:0] sample_t;

    // timer setup as held by the register file
    typedef struct packed {
        timer_a_t value_a;
        timer_b_t value_b;
        logic     load_a;
        logic     load_b;
        logic     irq_en_a;
        logic     irq_en_b;
        logic     clr_a;        // one cen tick
        logic     clr_b;        // one cen tick
    } timer_cfg_t;

    typedef struct packed {
        logic       keyon;
        logic [1:0] rl;         // bit1 left, bit0 right
        phase_t     freq;       // phase increment per sample
        level_t     arate;      // level step per sample, both directions
        logic [3:0] tl;         // attenuation as right shift
    } voice_cfg_t;

    typedef enum logic [1:0] {
        env_idle,
        env_attack,
        env_hold,
        env_release
    } env_state_t;

endpackage

`default_nettype wire

// File: src/fm_mmr.sv
// FM register file with chip bus decode, address latch, busy period and slot counter
`timescale 1ns/1ps
`default_nettype none
`include "fm_cfg.svh"

module fm_mmr (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 cen,
    input  wire                 cs_n,
    input  wire                 wr_n,
    input  wire                 a0,
    input  fm_pkg::fm_byte_t    din,
    output logic                busy,
    output logic                zero,
    output fm_pkg::timer_cfg_t  timer_cfg,
    output fm_pkg::voice_cfg_t  voice_cfg
);

    import fm_pkg::*;

    localparam int    BUSY_W    = $clog2(`FM_BUSY_CEN + 1);
    localparam slot_t LAST_SLOT = slot_t'(`FM_SLOTS - 1);

    logic              bus_wr;
    logic              addr_wr;
    logic              data_wr;
    fm_byte_t          addr;
    logic [BUSY_W-1:0] busy_cnt;
    slot_t             slot;

    assign bus_wr  = !cs_n && !wr_n;
    assign addr_wr = cen && bus_wr && !a0;           // accepted even while busy
    assign data_wr = cen && bus_wr && a0 && !busy;   // dropped while busy

    assign busy = (busy_cnt != '0);

    // address latch
    always_ff @(posedge clk) begin
        if (reset) begin
            addr <= '0;
        end else if (addr_wr) begin
            addr <= din;
        end
    end

    // busy down-counter restarted by any accepted data write
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= BUSY_W'(`FM_BUSY_CEN);
        end else if (cen && busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    // register file
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cfg <= '0;
            voice_cfg <= '0;
        end else if (cen) begin
            // clear requests only last one cen tick
            timer_cfg.clr_a <= 1'b0;
            timer_cfg.clr_b <= 1'b0;
            if (data_wr) begin
                case (addr)
                    `FM_REG_KEYON: begin
                        voice_cfg.keyon <= |din[6:3];  // any operator slot bit keys on
                    end
                    `FM_REG_CLKA1: begin
                        timer_cfg.value_a[9:2] <= din;
                    end
                    `FM_REG_CLKA2: begin
                        timer_cfg.value_a[1:0] <= din[1:0];
                    end
                    `FM_REG_CLKB: begin
                        timer_cfg.value_b <= din;
                    end
                    `FM_REG_TIMER_CTRL: begin
                        timer_cfg.load_a   <= din[0];
                        timer_cfg.load_b   <= din[1];
                        timer_cfg.irq_en_a <= din[2];
                        timer_cfg.irq_en_b <= din[3];
                        timer_cfg.clr_a    <= din[4];
                        timer_cfg.clr_b    <= din[5];
                    end
                    `FM_REG_RL: begin
                        voice_cfg.rl <= din[7:6];      // bit7 left and bit6 right
                    end
                    `FM_REG_FREQ_HI: begin
                        voice_cfg.freq[15:8] <= din;
                    end
                    `FM_REG_FREQ_LO: begin
                        voice_cfg.freq[7:0] <= din;
                    end
                    `FM_REG_TL: begin
                        voice_cfg.tl <= din[3:0];
                    end
                    `FM_REG_AR: begin
                        voice_cfg.arate <= din[6:0];
                    end
                    default: begin
                        // unknown address only starts busy
                    end
                endcase
            end
        end
    end

    // slot counter with zero marking the tick after the last slot
    always_ff @(posedge clk) begin
        if (reset) begin
            slot <= '0;
            zero <= 1'b0;
        end else if (cen) begin
            slot <= slot + 1'b1;
            zero <= (slot == LAST_SLOT);
        end
    end

endmodule

`default_nettype wire

// File: src/fm_timers.sv
// FM timers: timer A and B up-counters, sticky overflow flags and interrupt
`timescale 1ns/1ps
`default_nettype none
`include "fm_cfg.svh"

module fm_timers (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 cen,
    input  wire                 zero,
    input  fm_pkg::timer_cfg_t  timer_cfg,
    output logic                flag_a,
    output logic                flag_b,
    output logic                irq_n
);

    import fm_pkg::*;

    localparam int               PRE_W    = $clog2(`FM_TB_PRESCALE);
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`FM_TB_PRESCALE - 1);

    logic             tick;     // one per sample
    timer_a_t         cnt_a;
    timer_b_t         cnt_b;
    logic [PRE_W-1:0] pre_cnt;
    logic             wrap_a;
    logic             step_b;
    logic             wrap_b;

    assign tick   = cen && zero;
    assign wrap_a = timer_cfg.load_a && tick && (cnt_a == '1);
    assign step_b = timer_cfg.load_b && tick && (pre_cnt == PRE_LAST);
    assign wrap_b = step_b && (cnt_b == '1);

    // timer A, one count per sample
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_a <= '0;
        end else if (!timer_cfg.load_a || wrap_a) begin
            cnt_a <= timer_cfg.value_a;
        end else if (tick) begin
            cnt_a <= cnt_a + 1'b1;
        end
    end

    // timer B prescaler and counter
    always_ff @(posedge clk) begin
        if (reset) begin
            pre_cnt <= '0;
            cnt_b   <= '0;
        end else if (!timer_cfg.load_b) begin
            pre_cnt <= '0;
            cnt_b   <= timer_cfg.value_b;
        end else if (tick) begin
            pre_cnt <= pre_cnt + 1'b1;   // wraps on its own
            if (wrap_b) begin
                cnt_b <= timer_cfg.value_b;
            end else if (step_b) begin
                cnt_b <= cnt_b + 1'b1;
            end
        end
    end

    // sticky flags, an overflow wins over a clear on the same tick
    always_ff @(posedge clk) begin
        if (reset) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (wrap_a) begin
                flag_a <= 1'b1;
            end else if (cen && timer_cfg.clr_a) begin
                flag_a <= 1'b0;
            end
            if (wrap_b) begin
                flag_b <= 1'b1;
            end else if (cen && timer_cfg.clr_b) begin
                flag_b <= 1'b0;
            end
        end
    end

    assign irq_n = !((flag_a && timer_cfg.irq_en_a) || (flag_b && timer_cfg.irq_en_b));

endmodule

`default_nettype wire

// File: src/fm_voice.sv
// FM voice: phase accumulator, linear envelope, triangle wave and channel gating
`timescale 1ns/1ps
`default_nettype none

module fm_voice (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 cen,
    input  wire                 zero,
    input  fm_pkg::voice_cfg_t  voice_cfg,
    output fm_pkg::sample_t     xleft,
    output fm_pkg::sample_t     xright
);

    import fm_pkg::*;

    logic              tick;
    phase_t            phase;
    env_state_t        state;
    level_t            level;
    logic [7:0]        rise_sum;
    logic              rise_full;
    logic              fall_empty;
    logic [7:0]        wave_idx;    // top phase bits
    logic [5:0]        fold;
    logic [6:0]        mag;
    logic signed [7:0] tri_wave;
    logic signed [7:0] level_s;
    sample_t           prod;
    sample_t           scaled;

    assign tick = cen && zero;

    // phase advances once per sample
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
        end else if (tick) begin
            phase <= phase + voice_cfg.freq;
        end
    end

    // envelope step helpers
    assign rise_sum   = {1'b0, level} + {1'b0, voice_cfg.arate};
    assign rise_full  = rise_sum[7] || (rise_sum[6:0] == '1) || (voice_cfg.arate == '0);
    assign fall_empty = (level <= voice_cfg.arate) || (voice_cfg.arate == '0);

    // envelope FSM
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= env_idle;
            level <= '0;
        end else if (tick) begin
            unique case (state)
                env_idle: begin
                    if (voice_cfg.keyon) begin
                        state <= env_attack;
                    end
                end
                env_attack: begin
                    if (!voice_cfg.keyon) begin
                        state <= env_release;
                    end else if (rise_full) begin
                        level <= '1;        // saturate
                        state <= env_hold;
                    end else begin
                        level <= rise_sum[6:0];
                    end
                end
                env_hold: begin
                    if (!voice_cfg.keyon) begin
                        state <= env_release;
                    end
                end
                env_release: begin
                    if (voice_cfg.keyon) begin
                        state <= env_attack;  // retrigger from current level
                    end else if (fall_empty) begin
                        level <= '0;
                        state <= env_idle;
                    end else begin
                        level <= level - voice_cfg.arate;
                    end
                end
            endcase
        end
    end

    // triangle from the top 8 phase bits
    // bit7 picks the sign, bit6 the slope direction
    assign wave_idx = phase[15:8];
    assign fold     = wave_idx[6] ? ~wave_idx[5:0] : wave_idx[5:0];
    assign mag      = {fold, fold[5]};                  // 0..127
    assign tri_wave = wave_idx[7] ? -$signed({1'b0, mag}) : $signed({1'b0, mag});

    assign level_s = $signed({1'b0, level});
    assign prod    = tri_wave * level_s;                // fits in 15 bits plus sign
    assign scaled  = prod >>> voice_cfg.tl;

    // gated channel outputs, one update per sample
    always_ff @(posedge clk) begin
        if (reset) begin
            xleft  <= '0;
            xright <= '0;
        end else if (tick) begin
            xleft  <= voice_cfg.rl[1] ? scaled : '0;
            xright <= voice_cfg.rl[0] ? scaled : '0;
        end
    end

endmodule

`default_nettype wire

// File: src/fm_top.sv
// FM core top level: chip bus, status byte, timers and single voice with DAC outputs
`timescale 1ns/1ps
`default_nettype none

module fm_top (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 cen,
    input  wire                 cs_n,
    input  wire                 wr_n,
    input  wire                 a0,
    input  fm_pkg::fm_byte_t    din,
    output fm_pkg::fm_byte_t    dout,
    output logic                irq_n,
    output logic                sample,
    output fm_pkg::sample_t     xleft,
    output fm_pkg::sample_t     xright,
    output logic [15:0]         dacleft,    // offset binary
    output logic [15:0]         dacright
);

    import fm_pkg::*;

    logic       busy;
    logic       zero;
    logic       flag_a;
    logic       flag_b;
    timer_cfg_t timer_cfg;
    voice_cfg_t voice_cfg;

    fm_mmr u_mmr (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cen       ( cen       ),
        .cs_n      ( cs_n      ),
        .wr_n      ( wr_n      ),
        .a0        ( a0        ),
        .din       ( din       ),
        .busy      ( busy      ),
        .zero      ( zero      ),
        .timer_cfg ( timer_cfg ),
        .voice_cfg ( voice_cfg )
    );

    fm_timers u_timers (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cen       ( cen       ),
        .zero      ( zero      ),
        .timer_cfg ( timer_cfg ),
        .flag_a    ( flag_a    ),
        .flag_b    ( flag_b    ),
        .irq_n     ( irq_n     )
    );

    fm_voice u_voice (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cen       ( cen       ),
        .zero      ( zero      ),
        .voice_cfg ( voice_cfg ),
        .xleft     ( xleft     ),
        .xright    ( xright    )
    );

    assign dout     = {busy, 5'b0, flag_b, flag_a};   // status byte
    assign sample   = zero;
    assign dacleft  = {~xleft[15],  xleft[14:0]};
    assign dacright = {~xright[15], xright[14:0]};

endmodule

`default_nettype wire

// File: dv/fm_tb.sv
// FM core testbench with chip bus writes, timer flags, envelope and channel gating checks
`timescale 1ns/1ps
`default_nettype none
`include "fm_cfg.svh"

module fm_tb;

    import fm_pkg::*;

    localparam phase_t FREQ   = 16'h0800;
    localparam int     PERIOD = 65536 / FREQ;    // samples per phase cycle
    localparam int     PEAK   = 127 * 127;       // triangle apex at full level

    logic        clk = 1'b0;
    logic        reset;
    logic        cen;
    logic        cs_n;
    logic        wr_n;
    logic        a0;
    fm_byte_t    din;
    fm_byte_t    dout;
    logic        irq_n;
    logic        sample;
    sample_t     xleft;
    sample_t     xright;
    logic [15:0] dacleft;
    logic [15:0] dacright;
    int          errors = 0;
    int          checks = 0;
    int          seed   = 63;

    fm_top DUT (.*);

    always #20 clk = ~clk;

    always @(negedge clk) begin
        cen <= ~cen;    // chip clock enable at half rate
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic confirm(input string what, input logic cond);
        checks++;
        assert (cond) else begin
            $display("failed at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    // one bus cycle held over two clocks so exactly one cen-high edge sees it
    task automatic drive_cycle(input logic addr_sel, input fm_byte_t data);
        @(negedge clk);
        a0   = addr_sel;
        din  = data;
        cs_n = 1'b0;
        wr_n = 1'b0;
        repeat (2) @(negedge clk);
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic wait_not_busy();
        int n = 0;
        while (dout[7] && n < 2 * `FM_BUSY_CEN + 8) begin
            @(negedge clk);
            n++;
        end
        if (dout[7]) begin
            $display("timeout at %0t ns: busy never cleared", $time);
            errors++;
        end
    endtask

    task automatic bus_write(input fm_byte_t addr, input fm_byte_t data);
        wait_not_busy();
        drive_cycle(1'b0, addr);
        drive_cycle(1'b1, data);
    endtask

    // returns once the strobe has ended and its sample tick is done
    task automatic wait_sample();
        int n = 0;
        while (!sample && n < 100) begin
            @(negedge clk);
            n++;
        end
        while (sample && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (n >= 100) begin
            $display("timeout at %0t ns: no sample pulse", $time);
            errors++;
        end
    endtask

    task automatic count_to_flag(input int idx, input int limit, output int n);
        n = 0;
        while (!dout[idx] && n < limit) begin
            wait_sample();
            n++;
        end
    endtask

    task automatic poll_flag_low(input int idx);
        int n = 0;
        while (dout[idx] && n < 16) begin
            @(negedge clk);
            n++;
        end
    endtask

    // positive xleft peak over one phase cycle while the right channel stays silent
    task automatic left_channel_peak(output int peak);
        int last;
        int changes = 0;
        peak = 0;
        last = int'(xleft);
        repeat (PERIOD) begin
            wait_sample();
            compare("xright", 32'(xright), 32'h0);
            if (int'(xleft) != last) begin
                changes++;
            end
            if (int'(xleft) > peak) begin
                peak = int'(xleft);
            end
            last = int'(xleft);
        end
        confirm("xleft varies over a phase cycle", changes > 0);
    endtask

    task automatic summarize_test(input string name, input int start);
        $display("%s: %0d errors", name, errors - start);
    endtask

    task automatic reset_and_busy();
        compare("dout", 32'(dout), 32'h00);
        compare("irq_n", 32'(irq_n), 32'h1);
        compare("dacleft", 32'(dacleft), 32'h8000);
        compare("dacright", 32'(dacright), 32'h8000);
        compare("xleft", 32'(xleft), 32'h0);
        compare("xright", 32'(xright), 32'h0);
        bus_write(`FM_REG_CLKB, 8'd254);
        compare("dout[7]", 32'(dout[7]), 32'h1);
        drive_cycle(1'b0, `FM_REG_CLKB);     // lands inside the busy window
        drive_cycle(1'b1, 8'h00);
        wait_not_busy();
        compare("dout[7]", 32'(dout[7]), 32'h0);
    endtask

    // strobe width and spacing in clocks, cen is high every second clock
    task automatic sample_timing();
        int width = 0;
        int period = 0;
        wait_sample();
        while (!sample && period < 4 * `FM_SLOTS) begin
            @(negedge clk);
            period++;
        end
        period = 0;
        while (sample && period < 4 * `FM_SLOTS) begin
            @(negedge clk);
            period++;
            width++;
        end
        while (!sample && period < 4 * `FM_SLOTS) begin
            @(negedge clk);
            period++;
        end
        compare("sample width", width, 2);
        compare("sample period", period, 2 * `FM_SLOTS);
    endtask

    task automatic timer_a_flags();
        timer_a_t va;
        int n;
        va = timer_a_t'(1016 + {$random(seed)} % 5);
        bus_write(`FM_REG_CLKA1, va[9:2]);
        bus_write(`FM_REG_CLKA2, {6'b0, va[1:0]});
        bus_write(`FM_REG_TIMER_CTRL, 8'h05);    // load_a, irq_en_a
        count_to_flag(0, 16, n);
        compare("flag_a", 32'(dout[0]), 32'h1);
        compare("samples to flag_a", n, 1024 - va);
        compare("irq_n", 32'(irq_n), 32'h0);
        bus_write(`FM_REG_TIMER_CTRL, 8'h15);    // clear A and keep counting
        poll_flag_low(0);
        compare("flag_a", 32'(dout[0]), 32'h0);
        compare("irq_n", 32'(irq_n), 32'h1);
        bus_write(`FM_REG_TIMER_CTRL, 8'h01);    // irq masked
        count_to_flag(0, 16, n);
        compare("flag_a", 32'(dout[0]), 32'h1);
        compare("irq_n", 32'(irq_n), 32'h1);
        bus_write(`FM_REG_TIMER_CTRL, 8'h10);
        poll_flag_low(0);
        compare("flag_a", 32'(dout[0]), 32'h0);
    endtask

    task automatic timer_b_flags();
        int n;
        bus_write(`FM_REG_TIMER_CTRL, 8'h02);    // load_b
        count_to_flag(1, 40, n);
        compare("flag_b", 32'(dout[1]), 32'h1);
        compare("samples to flag_b", n, (256 - 254) * `FM_TB_PRESCALE);
        compare("flag_a", 32'(dout[0]), 32'h0);
        bus_write(`FM_REG_TIMER_CTRL, 8'h20);
        poll_flag_low(1);
        compare("flag_b", 32'(dout[1]), 32'h0);
    endtask

    task automatic key_on_envelope();
        int n = 0;
        int zeros = 0;
        bus_write(`FM_REG_FREQ_HI, FREQ[15:8]);
        bus_write(`FM_REG_FREQ_LO, FREQ[7:0]);
        bus_write(`FM_REG_RL, 8'hc0);
        bus_write(`FM_REG_TL, 8'h00);
        bus_write(`FM_REG_AR, 8'd127);
        bus_write(`FM_REG_KEYON, 8'h78);
        while (xleft == '0 && n < 8) begin
            wait_sample();
            n++;
        end
        confirm("xleft nonzero after key on", xleft != '0);
        repeat (16) begin
            wait_sample();
            compare("xright", 32'(xright), 32'(xleft));
            compare("dacleft", 32'(dacleft), 32'(xleft ^ 16'h8000));
            compare("dacright", 32'(dacright), 32'(xright ^ 16'h8000));
        end
        bus_write(`FM_REG_KEYON, 8'h00);
        n = 0;
        // two silent samples in a row rule out a zero crossing
        while (zeros < 2 && n < 12) begin
            wait_sample();
            n++;
            zeros = (xleft == '0 && xright == '0) ? zeros + 1 : 0;
        end
        compare("silent samples after key off", zeros, 2);
    endtask

    task automatic channel_gating();
        int n = 0;
        int peak0;
        int peak2;
        bus_write(`FM_REG_RL, 8'h80);            // left only
        bus_write(`FM_REG_KEYON, 8'h78);
        while (xleft == '0 && n < 8) begin
            wait_sample();
            n++;
        end
        left_channel_peak(peak0);
        bus_write(`FM_REG_TL, 8'h02);
        wait_sample();
        left_channel_peak(peak2);
        compare("xleft peak with tl 0", peak0, PEAK);
        compare("xleft peak with tl 2", peak2, PEAK >> 2);
        bus_write(`FM_REG_KEYON, 8'h00);
    endtask

    initial begin
        int start;
        reset = 1'b1;
        cen   = 1'b0;
        cs_n  = 1'b1;
        wr_n  = 1'b1;
        a0    = 1'b0;
        din   = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        start = errors;
        reset_and_busy();
        summarize_test("reset and busy", start);
        start = errors;
        sample_timing();
        summarize_test("sample strobe", start);
        start = errors;
        timer_a_flags();
        summarize_test("timer A", start);
        start = errors;
        timer_b_flags();
        summarize_test("timer B", start);
        start = errors;
        key_on_envelope();
        summarize_test("key on and envelope", start);
        start = errors;
        channel_gating();
        summarize_test("channel gating", start);
        $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog for the whole run
    initial begin
        #2_000_000;
        $display("simulation did not finish in time");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: fm_core.f
+incdir+include
src/fm_pkg.sv
src/fm_mmr.sv
src/fm_timers.sv
src/fm_voice.sv
src/fm_top.sv
dv/fm_tb.sv

// File: Makefile
# Verilator build and run for the FM core testbench

VERILATOR  ?= verilator
TOP        := fm_tb
FILELIST   := fm_core.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only when the simulation prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx 'test passed'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
